// ==== bench/cgra_shell_asserts.sv ====
// protocol assertions for the shell top that the bind below attaches to cgra_shell_wrapper
module cgra_shell_asserts (
  input logic                                                clk_i,
  input logic                                                rst_n_i,
  input logic                                                in0_ready_i,
  input logic                                                in1_ready_i,
  input cgra_data_pkg::stream_word_t                         out_data_i,
  input logic                                                out_valid_i,
  input logic                                                out_ready_i,
  input logic                                                csr_set_ready_i,
  input cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RO_CSR-1:0] csr_ro_i,
  input logic                                                push_i,
  input cgra_data_pkg::stream_word_t                         push_data_i,
  input logic                                                fifo_empty_i,
  input cgra_data_pkg::stream_word_t                         pop_data_i
);

  // ----------------------------------------------------------
  // stream handshake rules
  // ----------------------------------------------------------
  // a stalled output word stays put until ready
  out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else $error("output valid dropped or data changed while stalled");

  // both lanes of the join handshake together
  ready_pair: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in0_ready_i == in1_ready_i)
    else $error("input lane readies differ");

  // no new job while one runs
  set_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_ro_i[cgra_cfg_pkg::CSR_BUSY_IDX][0] |-> !csr_set_ready_i)
    else $error("CSR set ready high while busy");

  // ----------------------------------------------------------
  // result FIFO rules
  // ----------------------------------------------------------
  // a word written into an empty FIFO is the head one cycle later
  head_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i && fifo_empty_i |=> !fifo_empty_i && pop_data_i == $past(push_data_i))
    else $error("result FIFO head does not hold the word written into it");

endmodule

bind cgra_shell_wrapper cgra_shell_asserts i_asserts (
  .clk_i           ( clk_i                ),
  .rst_n_i         ( rst_n_i              ),
  .in0_ready_i     ( stream2acc_0_ready_o ),
  .in1_ready_i     ( stream2acc_1_ready_o ),
  .out_data_i      ( acc2stream_0_data_o  ),
  .out_valid_i     ( acc2stream_0_valid_o ),
  .out_ready_i     ( acc2stream_0_ready_i ),
  .csr_set_ready_i ( csr_reg_set_ready_o  ),
  .csr_ro_i        ( csr_reg_ro_set_o     ),
  .push_i          ( push                 ),
  .push_data_i     ( push_data            ),
  .fifo_empty_i    ( fifo_empty           ),
  .pop_data_i      ( pop_data             )
);

// ==== bench/cgra_shell_checker.sv ====
// scoreboard for the shell, follows the DUT ports and checks results, job end and stream rules
module cgra_shell_checker (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RW_CSR-1:0] csr_set_i,
  input  logic                                                csr_set_valid_i,
  input  logic                                                csr_set_ready_i,
  input  cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RO_CSR-1:0] csr_ro_i,
  input  cgra_data_pkg::stream_word_t                         a_data_i,
  input  logic                                                a_valid_i,
  input  logic                                                a_ready_i,
  input  cgra_data_pkg::stream_word_t                         b_data_i,
  input  logic                                                b_valid_i,
  input  logic                                                b_ready_i,
  input  cgra_data_pkg::stream_word_t                         out_data_i,
  input  logic                                                out_valid_i,
  input  logic                                                out_ready_i,
  output int                                                  data_errors_o,
  output int                                                  other_errors_o
);

  cgra_data_pkg::stream_word_t expected_q [$];
  cgra_data_pkg::stream_word_t exp_word;
  cgra_data_pkg::stream_word_t prev_data;
  cgra_cfg_pkg::cgra_op_e      op_q;
  cgra_cfg_pkg::job_len_t      len_q;
  int unsigned                 in_count;
  int unsigned                 out_count;
  logic                        reset_checked;
  logic                        end_pending;
  logic                        prev_stall;

  // result by the operation rule, mul keeps the low half of the full product
  function automatic cgra_data_pkg::stream_word_t op_result(
    input cgra_cfg_pkg::cgra_op_e      op,
    input cgra_data_pkg::stream_word_t a,
    input cgra_data_pkg::stream_word_t b
  );
    logic [127:0] product;
    product = {64'd0, a} * {64'd0, b};
    case (op)
      cgra_cfg_pkg::OP_ADD: return a + b;
      cgra_cfg_pkg::OP_SUB: return a - b;
      cgra_cfg_pkg::OP_MUL: return product[63:0];
      default:              return a ^ b;
    endcase
  endfunction

  // sampled mid-cycle, inputs and outputs are settled there
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      expected_q.delete();
      len_q          = '0;
      op_q           = cgra_cfg_pkg::OP_ADD;
      in_count       = 0;
      out_count      = 0;
      reset_checked  = 1'b0;
      end_pending    = 1'b0;
      prev_stall     = 1'b0;
      data_errors_o  = 0;
      other_errors_o = 0;
    end else begin
      // ----------------------------------------------------------
      // state right after reset
      // ----------------------------------------------------------
      if (!reset_checked) begin
        if (out_valid_i || a_ready_i || b_ready_i || !csr_set_ready_i || csr_ro_i != '0) begin
          $display("after reset the ports are not idle at time %0t", $time);
          other_errors_o++;
        end
        reset_checked = 1'b1;
      end
      // one cycle after the last output word
      if (end_pending) begin
        if (csr_ro_i[cgra_cfg_pkg::CSR_BUSY_IDX][0] || !csr_set_ready_i) begin
          $display("job did not return to idle after its last word at time %0t", $time);
          other_errors_o++;
        end
        if (csr_ro_i[cgra_cfg_pkg::CSR_COUNT_IDX] != {16'd0, len_q}) begin
          $display("ERR %0t delivered count %0d, expected %0d", $time,
                   csr_ro_i[cgra_cfg_pkg::CSR_COUNT_IDX], len_q);
          data_errors_o++;
        end
        end_pending = 1'b0;
      end
      // new job
      if (csr_set_valid_i && csr_set_ready_i) begin
        op_q      = cgra_cfg_pkg::cgra_op_e'(csr_set_i[cgra_cfg_pkg::CSR_OP_IDX][1:0]);
        len_q     = csr_set_i[cgra_cfg_pkg::CSR_LEN_IDX][15:0];
        in_count  = 0;
        out_count = 0;
      end
      // ----------------------------------------------------------
      // input pairs and output words
      // ----------------------------------------------------------
      if (a_valid_i && a_ready_i && b_valid_i && b_ready_i) begin
        if (in_count >= 32'(len_q)) begin
          $display("input pair accepted beyond the job length at time %0t", $time);
          other_errors_o++;
        end
        expected_q.push_back(op_result(op_q, a_data_i, b_data_i));
        in_count++;
      end
      if (out_valid_i && out_ready_i) begin
        if (expected_q.size() == 0) begin
          $display("output word delivered with no result pending at time %0t", $time);
          other_errors_o++;
        end else begin
          exp_word = expected_q.pop_front();
          if (out_data_i !== exp_word) begin
            $display("ERR %0t result %0d got %h expected %h", $time, out_count,
                     out_data_i, exp_word);
            data_errors_o++;
          end
        end
        out_count++;
        if (out_count == 32'(len_q)) begin
          end_pending = 1'b1;
        end
      end
      // a stalled word must stay on the bus unchanged
      if (prev_stall && (!out_valid_i || out_data_i !== prev_data)) begin
        $display("output word changed or vanished while stalled at time %0t", $time);
        other_errors_o++;
      end
      prev_stall = out_valid_i && !out_ready_i;
      prev_data  = out_data_i;
    end
  end

endmodule

// ==== bench/cgra_shell_tb.sv ====
// top testbench for the shell, runs the job table through the DUT and prints the closing report
module cgra_shell_tb;

  // one job per row, stall in eighths of the cycles
  typedef struct packed {
    cgra_cfg_pkg::cgra_op_e      op;
    cgra_cfg_pkg::job_len_t      len;
    cgra_data_pkg::stream_word_t seed;
    logic [2:0]                  stall;
  } job_row_s;

  logic                                                clk;
  logic                                                rst_n;
  cgra_data_pkg::stream_word_t                         in0_data;
  logic                                                in0_valid;
  logic                                                in0_ready;
  cgra_data_pkg::stream_word_t                         in1_data;
  logic                                                in1_valid;
  logic                                                in1_ready;
  cgra_data_pkg::stream_word_t                         out_data;
  logic                                                out_valid;
  logic                                                out_ready;
  cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RW_CSR-1:0] csr_set;
  logic                                                csr_set_valid;
  logic                                                csr_set_ready;
  cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RO_CSR-1:0] csr_ro;
  int                                                  data_errors;
  int                                                  other_errors;
  job_row_s                                            jobs [6];
  logic [31:0]                                         lfsr_state;
  int unsigned                                         cycles;
  int unsigned                                         timeout_limit;

  cgra_shell_wrapper UUT (
    .clk_i                ( clk           ),
    .rst_n_i              ( rst_n         ),
    .stream2acc_0_data_i  ( in0_data      ),
    .stream2acc_0_valid_i ( in0_valid     ),
    .stream2acc_0_ready_o ( in0_ready     ),
    .stream2acc_1_data_i  ( in1_data      ),
    .stream2acc_1_valid_i ( in1_valid     ),
    .stream2acc_1_ready_o ( in1_ready     ),
    .acc2stream_0_data_o  ( out_data      ),
    .acc2stream_0_valid_o ( out_valid     ),
    .acc2stream_0_ready_i ( out_ready     ),
    .csr_reg_set_i        ( csr_set       ),
    .csr_reg_set_valid_i  ( csr_set_valid ),
    .csr_reg_set_ready_o  ( csr_set_ready ),
    .csr_reg_ro_set_o     ( csr_ro        )
  );

  cgra_shell_checker i_checker (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .csr_set_i       ( csr_set       ),
    .csr_set_valid_i ( csr_set_valid ),
    .csr_set_ready_i ( csr_set_ready ),
    .csr_ro_i        ( csr_ro        ),
    .a_data_i        ( in0_data      ),
    .a_valid_i       ( in0_valid     ),
    .a_ready_i       ( in0_ready     ),
    .b_data_i        ( in1_data      ),
    .b_valid_i       ( in1_valid     ),
    .b_ready_i       ( in1_ready     ),
    .out_data_i      ( out_data      ),
    .out_valid_i     ( out_valid     ),
    .out_ready_i     ( out_ready     ),
    .data_errors_o   ( data_errors   ),
    .other_errors_o  ( other_errors  )
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------
  // random bits, x^32 + x^22 + x^2 + x + 1
  // ----------------------------------------------------------
  function automatic logic lfsr_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // op, length, lane a seed, stall eighths
  task automatic load_job_table();
    jobs[0] = '{cgra_cfg_pkg::OP_ADD, 16'd12, 64'h0000_0000_0000_0100, 3'd0};
    jobs[1] = '{cgra_cfg_pkg::OP_SUB, 16'd16, 64'h0000_0000_0000_0005, 3'd3};
    jobs[2] = '{cgra_cfg_pkg::OP_MUL, 16'd16, 64'hffff_ffff_0000_0001, 3'd4};
    jobs[3] = '{cgra_cfg_pkg::OP_XOR, 16'd10, 64'h5a5a_0000_a5a5_0000, 3'd2};
    // back-to-back short and long jobs
    jobs[4] = '{cgra_cfg_pkg::OP_ADD, 16'd1,  64'hffff_ffff_ffff_ffff, 3'd0};
    jobs[5] = '{cgra_cfg_pkg::OP_MUL, 16'd20, 64'h0000_0001_0000_0003, 3'd4};
  endtask

  // ----------------------------------------------------------
  // one job, CSR set then operand pairs until busy clears
  // ----------------------------------------------------------
  task automatic run_job(input int j);
    cgra_data_pkg::stream_word_t b_word;
    int unsigned                 idx;
    logic                        busy;
    logic                        took;
    csr_set[cgra_cfg_pkg::CSR_OP_IDX]  = {30'd0, jobs[j].op};
    csr_set[cgra_cfg_pkg::CSR_LEN_IDX] = {16'd0, jobs[j].len};
    csr_set_valid = 1'b1;
    do @(negedge clk); while (!csr_set_ready);
    @(posedge clk);
    #1 csr_set_valid = 1'b0;
    idx    = 0;
    b_word = {2{rand_bits(32)}};
    busy   = 1'b1;
    while (busy) begin
      // pairs past the length keep being offered
      if (!in0_valid && rand_bits(1) == 32'd1) begin
        in0_valid = 1'b1;
        in0_data  = jobs[j].seed + 64'(idx);
      end
      if (!in1_valid && rand_bits(1) == 32'd1) begin
        in1_valid = 1'b1;
        in1_data  = b_word;
      end
      out_ready = (rand_bits(3) >= 32'(jobs[j].stall));
      @(negedge clk);
      took = in0_valid && in0_ready && in1_valid && in1_ready;
      busy = csr_ro[cgra_cfg_pkg::CSR_BUSY_IDX][0];
      @(posedge clk);
      #1;
      if (took) begin
        in0_valid = 1'b0;
        in1_valid = 1'b0;
        idx++;
        b_word = {2{rand_bits(32)}};
      end
    end
    in0_valid = 1'b0;
    in1_valid = 1'b0;
  endtask

  // ----------------------------------------------------------
  // timeout from the total job length
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("timeout, the jobs did not finish within %0d cycles", timeout_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    in0_data      = '0;
    in0_valid     = 1'b0;
    in1_data      = '0;
    in1_valid     = 1'b0;
    out_ready     = 1'b0;
    csr_set       = '0;
    csr_set_valid = 1'b0;
    cycles        = 0;
    lfsr_state    = 32'hc0a6_f20c;
    load_job_table();
    timeout_limit = 200;
    foreach (jobs[j]) begin
      timeout_limit += 32'(jobs[j].len) * 8;
    end
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    // operands offered before any set must wait
    in0_valid = 1'b1;
    in0_data  = 64'h0123_4567_89ab_cdef;
    in1_valid = 1'b1;
    in1_data  = 64'hfedc_ba98_7654_3210;
    repeat (3) @(posedge clk);
    #1;
    in0_valid = 1'b0;
    in1_valid = 1'b0;
    foreach (jobs[j]) begin
      run_job(j);
    end
    repeat (4) @(posedge clk);
    $display("closing report: %0d data errors, %0d other errors", data_errors, other_errors);
    if (data_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== cgra_shell.f ====
source/cgra_cfg_pkg.sv
source/cgra_data_pkg.sv
source/cgra_job_ctrl.sv
source/cgra_pe_row.sv
source/cgra_result_fifo.sv
source/cgra_stream_writer.sv
source/cgra_shell_wrapper.sv
bench/cgra_shell_asserts.sv
bench/cgra_shell_checker.sv
bench/cgra_shell_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; passes only if the pass message shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cgra_shell_tb -f cgra_shell.f \
  && ./obj_dir/Vcgra_shell_tb | tee /dev/stderr \
     | grep -q "Simulation completed successfully" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// ==== source/cgra_cfg_pkg.sv ====
// CSR-side definitions shared by the job controller, the processing row and the shell top
package cgra_cfg_pkg;

  // ----------------------------------------------------------
  // CSR layout
  // ----------------------------------------------------------
  localparam int unsigned NUM_RW_CSR = 2;
  localparam int unsigned NUM_RO_CSR = 2;

  // word index of each field in the rw and ro sets
  localparam int unsigned CSR_OP_IDX    = 0;
  localparam int unsigned CSR_LEN_IDX   = 1;
  localparam int unsigned CSR_BUSY_IDX  = 0;
  localparam int unsigned CSR_COUNT_IDX = 1;

  // one 32-bit register word
  typedef logic [31:0] csr_word_t;

  // number of results in one job, 1 to 65535
  typedef logic [15:0] job_len_t;

  // ----------------------------------------------------------
  // job description
  // ----------------------------------------------------------
  // element-wise operation, mul keeps the low 64 product bits
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_XOR = 2'd3
  } cgra_op_e;

  typedef struct packed {
    cgra_op_e op;
    job_len_t len;
  } job_cfg_s;

  // controller FSM
  typedef enum logic {
    S_IDLE = 1'b0,
    S_BUSY = 1'b1
  } job_state_e;

endpackage

// ==== source/cgra_data_pkg.sv ====
// data-path definitions for the stream words, operand pairs and the result FIFO
package cgra_data_pkg;

  // ----------------------------------------------------------
  // stream payload
  // ----------------------------------------------------------
  // one narrow stream word
  typedef logic [63:0] stream_word_t;

  // operand a from lane 0, operand b from lane 1
  typedef struct packed {
    stream_word_t a;
    stream_word_t b;
  } operand_pair_s;

  // ----------------------------------------------------------
  // result FIFO sizing
  // ----------------------------------------------------------
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);

  // index bits plus one wrap bit
  typedef logic [FIFO_AW:0] fifo_ptr_t;

endpackage

// ==== source/cgra_job_ctrl.sv ====
// job controller, takes CSR sets, tracks idle/busy and reports busy and delivered count
module cgra_job_ctrl (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  // rw CSR set from the CSR manager
  input  cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RW_CSR-1:0] csr_set_i,
  input  logic                                                csr_set_valid_i,
  output logic                                                csr_set_ready_o,
  // one pulse per output handshake
  input  logic                                                word_sent_i,
  // job setup towards the processing row
  output cgra_cfg_pkg::job_cfg_s                              job_cfg_o,
  output logic                                                job_start_o,
  // ro CSR words
  output cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RO_CSR-1:0] csr_ro_o
);

  cgra_cfg_pkg::job_state_e state_q;
  cgra_cfg_pkg::job_cfg_s   cfg_q;
  cgra_cfg_pkg::job_len_t   count_q;
  cgra_cfg_pkg::job_len_t   count_inc;
  logic                     accept;

  // ----------------------------------------------------------
  // CSR handshake
  // ----------------------------------------------------------
  // new sets only between jobs
  assign csr_set_ready_o = (state_q == cgra_cfg_pkg::S_IDLE);
  assign accept          = csr_set_valid_i & csr_set_ready_o;
  // row clears its issue counter on the same edge the config lands
  assign job_start_o     = accept;
  assign count_inc       = count_q + 16'd1;

  // ----------------------------------------------------------
  // state, config and delivered count
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= cgra_cfg_pkg::S_IDLE;
      cfg_q.op  <= cgra_cfg_pkg::OP_ADD;
      // zero length keeps the row's input readies low until a set
      cfg_q.len <= '0;
      count_q   <= '0;
    end else if (accept) begin
      state_q   <= cgra_cfg_pkg::S_BUSY;
      cfg_q.op  <= cgra_cfg_pkg::cgra_op_e'(csr_set_i[cgra_cfg_pkg::CSR_OP_IDX][1:0]);
      cfg_q.len <= csr_set_i[cgra_cfg_pkg::CSR_LEN_IDX][15:0];
      count_q   <= '0;
    end else if (state_q == cgra_cfg_pkg::S_BUSY && word_sent_i) begin
      count_q <= count_inc;
      // last word of the job, back to idle on this edge
      if (count_inc == cfg_q.len) begin
        state_q <= cgra_cfg_pkg::S_IDLE;
      end
    end
  end

  assign job_cfg_o = cfg_q;

  // ----------------------------------------------------------
  // read-only words
  // ----------------------------------------------------------
  always_comb begin
    csr_ro_o = '0;
    csr_ro_o[cgra_cfg_pkg::CSR_BUSY_IDX][0]     = (state_q == cgra_cfg_pkg::S_BUSY);
    // count stays at the length after the job ends
    csr_ro_o[cgra_cfg_pkg::CSR_COUNT_IDX][15:0] = count_q;
  end

endmodule

// ==== source/cgra_pe_row.sv ====
// processing row, joins the two operand lanes and registers one result per pair for the FIFO
module cgra_pe_row (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // job setup from the controller
  input  cgra_cfg_pkg::job_cfg_s      job_cfg_i,
  input  logic                        job_start_i,
  // lane 0, operand a
  input  cgra_data_pkg::stream_word_t a_data_i,
  input  logic                        a_valid_i,
  output logic                        a_ready_o,
  // lane 1, operand b
  input  cgra_data_pkg::stream_word_t b_data_i,
  input  logic                        b_valid_i,
  output logic                        b_ready_o,
  // result FIFO write side
  input  logic                        fifo_full_i,
  output logic                        push_o,
  output cgra_data_pkg::stream_word_t push_data_o
);

  cgra_data_pkg::operand_pair_s pair;
  cgra_data_pkg::stream_word_t  res_d;
  cgra_data_pkg::stream_word_t  res_q;
  logic                         res_valid_q;
  cgra_cfg_pkg::job_len_t       issued_q;
  logic                         slot_free;
  logic                         can_take;
  logic                         take;

  // ----------------------------------------------------------
  // input join
  // ----------------------------------------------------------
  // result register is empty or moves into the FIFO this cycle
  assign slot_free = ~res_valid_q | ~fifo_full_i;
  assign can_take  = (issued_q < job_cfg_i.len) & slot_free;
  // both lanes must be valid, so neither lane handshakes alone
  assign take      = can_take & a_valid_i & b_valid_i;
  assign a_ready_o = take;
  assign b_ready_o = take;

  assign pair.a = a_data_i;
  assign pair.b = b_data_i;

  // ----------------------------------------------------------
  // operation
  // ----------------------------------------------------------
  always_comb begin
    case (job_cfg_i.op)
      cgra_cfg_pkg::OP_ADD: res_d = pair.a + pair.b;
      cgra_cfg_pkg::OP_SUB: res_d = pair.a - pair.b;
      // low half of the 128-bit product
      cgra_cfg_pkg::OP_MUL: res_d = pair.a * pair.b;
      default:              res_d = pair.a ^ pair.b;
    endcase
  end

  // ----------------------------------------------------------
  // result register and issue counter
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
      issued_q    <= '0;
    end else begin
      if (job_start_i) begin
        issued_q <= '0;
      end else if (take) begin
        issued_q <= issued_q + 16'd1;
      end
      // a take refills the slot even while the old result drains
      if (take) begin
        res_valid_q <= 1'b1;
      end else if (push_o) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  // payload only, qualified by res_valid_q
  always_ff @(posedge clk_i) begin
    if (take) begin
      res_q <= res_d;
    end
  end

  assign push_o      = res_valid_q & ~fifo_full_i;
  assign push_data_o = res_q;

endmodule

// ==== source/cgra_result_fifo.sv ====
// result FIFO between the processing row and the stream writer, registered read, no fall-through
module cgra_result_fifo (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // write side
  input  logic                        push_i,
  input  cgra_data_pkg::stream_word_t push_data_i,
  output logic                        full_o,
  // read side
  input  logic                        pop_i,
  output cgra_data_pkg::stream_word_t pop_data_o,
  output logic                        empty_o
);

  localparam int unsigned AW = cgra_data_pkg::FIFO_AW;

  cgra_data_pkg::stream_word_t mem_q [cgra_data_pkg::FIFO_DEPTH];
  cgra_data_pkg::fifo_ptr_t    wr_ptr_q;
  cgra_data_pkg::fifo_ptr_t    rd_ptr_q;
  logic                        do_push;
  logic                        do_pop;

  // ----------------------------------------------------------
  // flags from the wrap-bit pointers
  // ----------------------------------------------------------
  // same index, different lap
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign empty_o = (wr_ptr_q == rd_ptr_q);

  // overflow and underflow are dropped here as well
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // ----------------------------------------------------------
  // pointers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[AW-1:0]] <= push_data_i;
    end
  end

  // head entry, valid when not empty
  assign pop_data_o = mem_q[rd_ptr_q[AW-1:0]];

endmodule

// ==== source/cgra_shell_wrapper.sv ====
// accelerator shell top with streamer and CSR manager port names, wires controller and data path
module cgra_shell_wrapper (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  // ----------------------------------------------------------
  // streamer to accelerator
  // ----------------------------------------------------------
  input  cgra_data_pkg::stream_word_t                         stream2acc_0_data_i,
  input  logic                                                stream2acc_0_valid_i,
  output logic                                                stream2acc_0_ready_o,
  input  cgra_data_pkg::stream_word_t                         stream2acc_1_data_i,
  input  logic                                                stream2acc_1_valid_i,
  output logic                                                stream2acc_1_ready_o,
  // ----------------------------------------------------------
  // accelerator to streamer
  // ----------------------------------------------------------
  output cgra_data_pkg::stream_word_t                         acc2stream_0_data_o,
  output logic                                                acc2stream_0_valid_o,
  input  logic                                                acc2stream_0_ready_i,
  // ----------------------------------------------------------
  // CSR manager
  // ----------------------------------------------------------
  input  cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RW_CSR-1:0] csr_reg_set_i,
  input  logic                                                csr_reg_set_valid_i,
  output logic                                                csr_reg_set_ready_o,
  output cgra_cfg_pkg::csr_word_t [cgra_cfg_pkg::NUM_RO_CSR-1:0] csr_reg_ro_set_o
);

  // controller to row
  cgra_cfg_pkg::job_cfg_s      job_cfg;
  logic                        job_start;
  // row to FIFO
  logic                        push;
  cgra_data_pkg::stream_word_t push_data;
  logic                        fifo_full;
  // FIFO to writer
  logic                        pop;
  cgra_data_pkg::stream_word_t pop_data;
  logic                        fifo_empty;
  // writer back to controller
  logic                        word_sent;

  cgra_job_ctrl i_job_ctrl (
    .clk_i           ( clk_i               ),
    .rst_n_i         ( rst_n_i             ),
    .csr_set_i       ( csr_reg_set_i       ),
    .csr_set_valid_i ( csr_reg_set_valid_i ),
    .csr_set_ready_o ( csr_reg_set_ready_o ),
    .word_sent_i     ( word_sent           ),
    .job_cfg_o       ( job_cfg             ),
    .job_start_o     ( job_start           ),
    .csr_ro_o        ( csr_reg_ro_set_o    )
  );

  cgra_pe_row i_pe_row (
    .clk_i       ( clk_i                ),
    .rst_n_i     ( rst_n_i              ),
    .job_cfg_i   ( job_cfg              ),
    .job_start_i ( job_start            ),
    .a_data_i    ( stream2acc_0_data_i  ),
    .a_valid_i   ( stream2acc_0_valid_i ),
    .a_ready_o   ( stream2acc_0_ready_o ),
    .b_data_i    ( stream2acc_1_data_i  ),
    .b_valid_i   ( stream2acc_1_valid_i ),
    .b_ready_o   ( stream2acc_1_ready_o ),
    .fifo_full_i ( fifo_full            ),
    .push_o      ( push                 ),
    .push_data_o ( push_data            )
  );

  cgra_result_fifo i_result_fifo (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .push_i      ( push       ),
    .push_data_i ( push_data  ),
    .full_o      ( fifo_full  ),
    .pop_i       ( pop        ),
    .pop_data_o  ( pop_data   ),
    .empty_o     ( fifo_empty )
  );

  cgra_stream_writer i_stream_writer (
    .clk_i       ( clk_i                ),
    .rst_n_i     ( rst_n_i              ),
    .empty_i     ( fifo_empty           ),
    .pop_o       ( pop                  ),
    .pop_data_i  ( pop_data             ),
    .out_data_o  ( acc2stream_0_data_o  ),
    .out_valid_o ( acc2stream_0_valid_o ),
    .out_ready_i ( acc2stream_0_ready_i ),
    .word_sent_o ( word_sent            )
  );

endmodule

// ==== source/cgra_stream_writer.sv ====
// stream writer, drains the result FIFO into the output stream and flags each delivered word
module cgra_stream_writer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // FIFO read side
  input  logic                        empty_i,
  output logic                        pop_o,
  input  cgra_data_pkg::stream_word_t pop_data_i,
  // output stream
  output cgra_data_pkg::stream_word_t out_data_o,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  // one pulse per handshake
  output logic                        word_sent_o
);

  cgra_data_pkg::stream_word_t out_q;
  logic                        out_valid_q;
  logic                        load;

  // register is empty or its word leaves this cycle
  assign load        = ~out_valid_q | out_ready_i;
  assign pop_o       = load & ~empty_i;
  assign word_sent_o = out_valid_q & out_ready_i;

  // ----------------------------------------------------------
  // output register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      // valid drops when nothing is waiting behind the sent word
      out_valid_q <= ~empty_i;
    end
  end

  // data holds while valid waits for ready
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      out_q <= pop_data_i;
    end
  end

  assign out_data_o  = out_q;
  assign out_valid_o = out_valid_q;

endmodule
